// File: list.f
logic/cpuPkg.sv
logic/controlUnit.sv
logic/memWaitTimer.sv
logic/registerFile.sv
logic/alu.sv
logic/memoryUnit.sv
logic/busDatapath.sv
logic/cpuTop.sv
tb/cpuTop_assertions.sv
tb/cpuTb.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - logic/cpuPkg.sv
  - logic/controlUnit.sv
  - logic/memWaitTimer.sv
  - logic/registerFile.sv
  - logic/alu.sv
  - logic/memoryUnit.sv
  - logic/busDatapath.sv
  - logic/cpuTop.sv
  - target: test
    files:
      - tb/cpuTop_assertions.sv
      - tb/cpuTb.sv

// File: tb/cpuTb.sv
`timescale 1ns/10ps

module cpuTb;

    localparam int RunLimit = 4000;

    logic clk;
    logic reset;
    logic start;
    logic stop;
    logic memLoad;
    cpuPkg::memAddrT memLoadAddr;
    cpuPkg::wordT memLoadData;
    logic run;
    cpuPkg::wordT outPort;
    logic outStrobe;

    // Instruction-level model of the program being built
    cpuPkg::wordT programWords [$];
    cpuPkg::wordT expected [$];
    cpuPkg::wordT modelRegs [16];
    cpuPkg::wordT modelMem [512];

    int errors = 0;
    int timeouts = 0;
    int outCount = 0;
    int assertFails;
    int baseCount;
    int countAtStop;

    cpuTop u_cpuTop (
        .clk(clk),
        .reset(reset),
        .start(start),
        .stop(stop),
        .memLoad(memLoad),
        .memLoadAddr(memLoadAddr),
        .memLoadData(memLoadData),
        .run(run),
        .outPort(outPort),
        .outStrobe(outStrobe)
    );

    always #20 clk = ~clk;

    task automatic checkValue(input string what, input cpuPkg::wordT got,
                              input cpuPkg::wordT exp);
        assert (got === exp)
        else begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset && outStrobe === 1'b1) begin
            outCount++;
            assert (expected.size() != 0)
            else begin
                errors++;
                $display("ERROR at %0t ns: out strobe with no value expected", $time);
            end
            if (expected.size() != 0) begin
                checkValue("outPort", outPort, expected.pop_front());
            end
        end
    end

    function automatic cpuPkg::wordT signExtend(input logic [18:0] c);
        return {{13{c[18]}}, c};
    endfunction

    // R0 as a base means address zero
    function automatic cpuPkg::wordT baseOf(input cpuPkg::regIndexT rb);
        return (rb == 0) ? '0 : modelRegs[rb];
    endfunction

    function automatic cpuPkg::wordT aluReference(input cpuPkg::opcodeT op,
                                                  input cpuPkg::wordT b,
                                                  input cpuPkg::wordT c);
        case (op)
            cpuPkg::OpAdd: return b + c;
            cpuPkg::OpSub: return b - c;
            cpuPkg::OpAnd: return b & c;
            cpuPkg::OpOr: return b | c;
            cpuPkg::OpShl: return b << c[4:0];
            cpuPkg::OpShr: return b >> c[4:0];
            cpuPkg::OpNeg: return -b;
            cpuPkg::OpNot: return ~b;
            default: return '0;
        endcase
    endfunction

    function automatic void clearModel();
        for (int i = 0; i < 16; i++) begin
            modelRegs[i] = '0;
        end
        programWords.delete();
        expected.delete();
    endfunction

    function automatic void emitLdi(input cpuPkg::regIndexT ra, input cpuPkg::regIndexT rb,
                                    input logic [18:0] c);
        programWords.push_back({cpuPkg::OpLdi, ra, rb, c});
        modelRegs[ra] = baseOf(rb) + signExtend(c);
    endfunction

    function automatic void emitLd(input cpuPkg::regIndexT ra, input cpuPkg::regIndexT rb,
                                   input logic [18:0] c);
        cpuPkg::wordT addr;
        addr = baseOf(rb) + signExtend(c);
        programWords.push_back({cpuPkg::OpLd, ra, rb, c});
        modelRegs[ra] = modelMem[addr[8:0]];
    endfunction

    function automatic void emitSt(input cpuPkg::regIndexT ra, input cpuPkg::regIndexT rb,
                                   input logic [18:0] c);
        cpuPkg::wordT addr;
        addr = baseOf(rb) + signExtend(c);
        programWords.push_back({cpuPkg::OpSt, ra, rb, c});
        modelMem[addr[8:0]] = modelRegs[ra];
    endfunction

    function automatic void emitAlu(input cpuPkg::opcodeT op, input cpuPkg::regIndexT ra,
                                    input cpuPkg::regIndexT rb, input cpuPkg::regIndexT rc);
        programWords.push_back({op, ra, rb, rc, 15'd0});
        modelRegs[ra] = aluReference(op, modelRegs[rb], modelRegs[rc]);
    endfunction

    function automatic void emitOut(input cpuPkg::regIndexT ra);
        programWords.push_back({cpuPkg::OpOut, ra, 23'd0});
        expected.push_back(modelRegs[ra]);
    endfunction

    task automatic applyReset();
        @(posedge clk);
        #5;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;
    endtask

    // Memory only accepts these writes while the CPU is idle
    task automatic loadProgram();
        for (int i = 0; i < programWords.size(); i++) begin
            @(posedge clk);
            #5;
            memLoad = 1'b1;
            memLoadAddr = cpuPkg::memAddrT'(i);
            memLoadData = programWords[i];
        end
        @(posedge clk);
        #5;
        memLoad = 1'b0;
    endtask

    task automatic pulseStart();
        @(posedge clk);
        #5;
        start = 1'b1;
        @(posedge clk);
        #5;
        start = 1'b0;
    endtask

    task automatic waitRunLevel(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (run !== level && cycles < RunLimit) begin
            @(posedge clk);
            #5;
            cycles++;
        end
        if (run !== level) begin
            timeouts++;
            $display("Timeout while waiting for %s", what);
        end
    endtask

    task automatic waitOutCount(input int target);
        int cycles;
        cycles = 0;
        while (outCount < target && cycles < RunLimit) begin
            @(posedge clk);
            #5;
            cycles++;
        end
        if (outCount < target) begin
            timeouts++;
            $display("Timeout while waiting for output strobe number %0d", target);
        end
    endtask

    initial begin
        void'($urandom(88));
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        stop = 1'b0;
        memLoad = 1'b0;
        memLoadAddr = '0;
        memLoadData = '0;
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;

        checkValue("run after reset", run, 1'b0);
        checkValue("outStrobe after reset", outStrobe, 1'b0);
        checkValue("outPort after reset", outPort, '0);

        clearModel();
        // Negative, positive and based constants
        emitLdi(1, 0, 19'h7FFFB);
        emitOut(1);
        emitLdi(2, 0, 19'd12345);
        emitOut(2);
        emitLdi(3, 2, 19'h7FF00);
        emitOut(3);
        for (int i = 0; i < 8; i++) begin
            emitLdi(4, 0, 19'($urandom()));
            emitLdi(5, 0, 19'($urandom()));
            emitAlu(cpuPkg::opcodeT'(int'(cpuPkg::OpAdd) + i), 6, 4, 5);
            emitOut(6);
        end
        // Nonzero R0, so a zero base only comes from absolute addressing
        emitLdi(0, 0, 19'd77);
        // Store at 300 + 5, read back through base 200 and absolute
        emitLdi(7, 0, 19'd300);
        emitLdi(8, 0, 19'($urandom()));
        emitSt(8, 7, 19'd5);
        emitLdi(9, 0, 19'd200);
        emitLd(10, 9, 19'd105);
        emitOut(10);
        emitLd(11, 0, 19'd305);
        emitOut(11);
        emitLdi(12, 0, 19'($urandom()));
        emitSt(12, 7, 19'h7FFF6);
        emitLd(13, 0, 19'd290);
        emitOut(13);
        programWords.push_back({cpuPkg::OpHalt, 27'd0});
        // Never reached after halt
        programWords.push_back({cpuPkg::OpOut, 4'd1, 23'd0});

        loadProgram();
        pulseStart();
        waitRunLevel(1'b1, "run to rise after start");
        waitRunLevel(1'b0, "run to fall after halt");
        baseCount = outCount;
        repeat (20) @(posedge clk);
        checkValue("outputs left after halt", expected.size(), 0);
        checkValue("strobes after halt", outCount, baseCount);

        // Second run, stopped partway
        applyReset();
        clearModel();
        for (int i = 0; i < 6; i++) begin
            emitLdi(cpuPkg::regIndexT'(i + 1), 0, 19'($urandom()));
            emitOut(cpuPkg::regIndexT'(i + 1));
        end
        programWords.push_back({cpuPkg::OpHalt, 27'd0});
        loadProgram();
        baseCount = outCount;
        pulseStart();
        waitRunLevel(1'b1, "run to rise on the second start");
        waitOutCount(baseCount + 2);
        stop = 1'b1;
        countAtStop = outCount;
        waitRunLevel(1'b0, "run to fall after stop");
        checkValue("strobes after stop", outCount, countAtStop);
        checkValue("strobes before stop", countAtStop - baseCount, 2);
        stop = 1'b0;
        expected.delete();

        repeat (5) @(posedge clk);
        assertFails = u_cpuTop.u_cpuTopAssertions.failCount;
        $display("Check errors: %0d, timeouts: %0d, assertion failures: %0d",
                 errors, timeouts, assertFails);
        if (errors == 0 && timeouts == 0 && assertFails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: tb/cpuTop_assertions.sv
`timescale 1ns/10ps

module cpuTopAssertions (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic run,
    input  logic outStrobe,
    input  cpuPkg::wordT outPort,
    input  logic memRead,
    input  logic memWrite,
    input  cpuPkg::ctrlStateT state
);

    int failCount = 0;

    // CPU stays stopped in Idle until start, and in Halted for good
    stoppedStatesNoRun: assert property (@(posedge clk) disable iff (reset)
        ((state == cpuPkg::Idle && !start) || state == cpuPkg::Halted) |=> !run)
    else begin
        failCount++;
        $error("run went high without start from a stopped control FSM");
    end

    // One memory access at a time
    readWriteExclusive: assert property (@(posedge clk) disable iff (reset)
        !(memRead && memWrite))
    else begin
        failCount++;
        $error("memRead and memWrite are high together");
    end

    singleCycleStrobe: assert property (@(posedge clk) disable iff (reset)
        outStrobe |=> !outStrobe)
    else begin
        failCount++;
        $error("outStrobe lasted longer than one cycle");
    end

    // Output port only moves together with the strobe
    outPortOnStrobe: assert property (@(posedge clk) disable iff (reset)
        !$stable(outPort) |-> outStrobe)
    else begin
        failCount++;
        $error("outPort changed without outStrobe");
    end

endmodule

bind cpuTop cpuTopAssertions u_cpuTopAssertions (
    .clk(clk),
    .reset(reset),
    .start(start),
    .run(run),
    .outStrobe(outStrobe),
    .outPort(outPort),
    .memRead(memRead),
    .memWrite(memWrite),
    .state(u_controlUnit.state)
);

// File: logic/cpuTop.sv
`timescale 1ns/10ps

module cpuTop (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic stop,
    input  logic memLoad,
    input  cpuPkg::memAddrT memLoadAddr,
    input  cpuPkg::wordT memLoadData,
    output logic run,
    output cpuPkg::wordT outPort,
    output logic outStrobe
);

    logic regOut;
    logic pcOut;
    logic mdrOut;
    logic zLowOut;
    logic cOut;
    logic regIn;
    logic pcIn;
    logic irIn;
    logic yIn;
    logic zIn;
    logic outPortIn;
    logic incPc;
    cpuPkg::aluOpT aluOp;
    logic gra;
    logic grb;
    logic grc;
    logic baOut;
    logic marIn;
    logic mdrIn;
    logic memRead;
    logic memWrite;
    logic memReady;
    cpuPkg::opcodeT opcode;
    cpuPkg::wordT busValue;
    cpuPkg::wordT mdrValue;

    controlUnit u_controlUnit (
        .clk(clk),
        .reset(reset),
        .start(start),
        .stop(stop),
        .opcode(opcode),
        .memReady(memReady),
        .run(run),
        .regOut(regOut),
        .pcOut(pcOut),
        .mdrOut(mdrOut),
        .zLowOut(zLowOut),
        .cOut(cOut),
        .regIn(regIn),
        .pcIn(pcIn),
        .irIn(irIn),
        .yIn(yIn),
        .zIn(zIn),
        .outPortIn(outPortIn),
        .incPc(incPc),
        .aluOp(aluOp),
        .gra(gra),
        .grb(grb),
        .grc(grc),
        .baOut(baOut),
        .marIn(marIn),
        .mdrIn(mdrIn),
        .memRead(memRead),
        .memWrite(memWrite)
    );

    memWaitTimer u_memWaitTimer (
        .clk(clk),
        .reset(reset),
        .memRead(memRead),
        .memReady(memReady)
    );

    busDatapath u_busDatapath (
        .clk(clk),
        .reset(reset),
        .regOut(regOut),
        .pcOut(pcOut),
        .mdrOut(mdrOut),
        .zLowOut(zLowOut),
        .cOut(cOut),
        .regIn(regIn),
        .pcIn(pcIn),
        .irIn(irIn),
        .yIn(yIn),
        .zIn(zIn),
        .outPortIn(outPortIn),
        .incPc(incPc),
        .aluOp(aluOp),
        .gra(gra),
        .grb(grb),
        .grc(grc),
        .baOut(baOut),
        .mdrValue(mdrValue),
        .busValue(busValue),
        .opcode(opcode),
        .outPort(outPort),
        .outStrobe(outStrobe)
    );

    memoryUnit u_memoryUnit (
        .clk(clk),
        .reset(reset),
        .busIn(busValue),
        .marIn(marIn),
        .mdrIn(mdrIn),
        .memRead(memRead),
        .memWrite(memWrite),
        .memLoad(memLoad),
        .memLoadAddr(memLoadAddr),
        .memLoadData(memLoadData),
        .run(run),
        .mdrValue(mdrValue)
    );

endmodule

// File: logic/busDatapath.sv
`timescale 1ns/10ps

module busDatapath (
    input  logic clk,
    input  logic reset,
    input  logic regOut,
    input  logic pcOut,
    input  logic mdrOut,
    input  logic zLowOut,
    input  logic cOut,
    input  logic regIn,
    input  logic pcIn,
    input  logic irIn,
    input  logic yIn,
    input  logic zIn,
    input  logic outPortIn,
    input  logic incPc,
    input  cpuPkg::aluOpT aluOp,
    input  logic gra,
    input  logic grb,
    input  logic grc,
    input  logic baOut,
    input  cpuPkg::wordT mdrValue,
    output cpuPkg::wordT busValue,
    output cpuPkg::opcodeT opcode,
    output cpuPkg::wordT outPort,
    output logic outStrobe
);

    cpuPkg::wordT pc;
    cpuPkg::wordT ir;
    cpuPkg::wordT y;
    cpuPkg::wordT z;
    cpuPkg::wordT regData;
    cpuPkg::wordT aluResult;
    cpuPkg::wordT cValue;

    // C field, sign-extended
    assign cValue = {{(cpuPkg::DataWidth - cpuPkg::ConstWidth){ir[cpuPkg::ConstWidth-1]}},
                     ir[cpuPkg::ConstWidth-1:0]};

    always_comb begin
        if (regOut) begin
            busValue = regData;
        end else if (pcOut) begin
            busValue = pc;
        end else if (mdrOut) begin
            busValue = mdrValue;
        end else if (zLowOut) begin
            busValue = z;
        end else if (cOut) begin
            busValue = cValue;
        end else begin
            busValue = '0;
        end
    end

    // Lets Fetch2 dispatch on the instruction it is loading
    assign opcode = irIn ? busValue[31:27] : ir[31:27];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
            ir <= '0;
            y <= '0;
            z <= '0;
            outPort <= '0;
            outStrobe <= 1'b0;
        end else begin
            if (pcIn) pc <= busValue;
            if (irIn) ir <= busValue;
            if (yIn) y <= busValue;
            if (zIn) z <= aluResult;
            if (outPortIn) outPort <= busValue;
            outStrobe <= outPortIn;
        end
    end

    registerFile u_registerFile (
        .clk(clk),
        .reset(reset),
        .ir(ir),
        .gra(gra),
        .grb(grb),
        .grc(grc),
        .baOut(baOut),
        .regIn(regIn),
        .busIn(busValue),
        .regData(regData)
    );

    alu u_alu (
        .aluOp(aluOp),
        .yValue(y),
        .busValue(busValue),
        .incPc(incPc),
        .result(aluResult)
    );

endmodule

// File: logic/memoryUnit.sv
`timescale 1ns/10ps

module memoryUnit (
    input  logic clk,
    input  logic reset,
    input  cpuPkg::wordT busIn,
    input  logic marIn,
    input  logic mdrIn,
    input  logic memRead,
    input  logic memWrite,
    input  logic memLoad,
    input  cpuPkg::memAddrT memLoadAddr,
    input  cpuPkg::wordT memLoadData,
    input  logic run,
    output cpuPkg::wordT mdrValue
);

    cpuPkg::memAddrT mar;
    cpuPkg::wordT mdr;
    cpuPkg::wordT mdrNext;
    cpuPkg::wordT ramWriteData;
    cpuPkg::wordT ram [cpuPkg::MemDepth];

    assign mdrNext = memRead ? ram[mar] : busIn;
    // A store sees the word MDR takes in the same cycle
    assign ramWriteData = mdrIn ? mdrNext : mdr;
    assign mdrValue = mdr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (marIn) begin
                mar <= busIn[cpuPkg::MemAddrWidth-1:0];
            end
            if (mdrIn) begin
                mdr <= mdrNext;
            end
        end
    end

    // Program load owns the port while the CPU is stopped
    always_ff @(posedge clk) begin
        if (!run && memLoad) begin
            ram[memLoadAddr] <= memLoadData;
        end else if (memWrite) begin
            ram[mar] <= ramWriteData;
        end
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/10ps

module alu (
    input  cpuPkg::aluOpT aluOp,
    input  cpuPkg::wordT yValue,
    input  cpuPkg::wordT busValue,
    input  logic incPc,
    output cpuPkg::wordT result
);

    logic [cpuPkg::ShiftWidth-1:0] shiftAmount;

    // Shift distance from the low bits of rc
    assign shiftAmount = busValue[cpuPkg::ShiftWidth-1:0];

    always_comb begin
        if (incPc) begin
            result = busValue + cpuPkg::wordT'(1);
        end else begin
            case (aluOp)
                cpuPkg::AluAdd: result = yValue + busValue;
                cpuPkg::AluSub: result = yValue - busValue;
                cpuPkg::AluAnd: result = yValue & busValue;
                cpuPkg::AluOr: result = yValue | busValue;
                cpuPkg::AluShl: result = yValue << shiftAmount;
                // logical, zero fill
                cpuPkg::AluShr: result = yValue >> shiftAmount;
                // Unary ops work on rb, held in Y
                cpuPkg::AluNeg: result = '0 - yValue;
                cpuPkg::AluNot: result = ~yValue;
                default: result = '0;
            endcase
        end
    end

endmodule

// File: logic/registerFile.sv
`timescale 1ns/10ps

module registerFile (
    input  logic clk,
    input  logic reset,
    input  cpuPkg::wordT ir,
    input  logic gra,
    input  logic grb,
    input  logic grc,
    input  logic baOut,
    input  logic regIn,
    input  cpuPkg::wordT busIn,
    output cpuPkg::wordT regData
);

    cpuPkg::wordT regs [cpuPkg::NumRegs];
    cpuPkg::regIndexT sel;

    // IR fields: ra 26:23, rb 22:19, rc 18:15
    always_comb begin
        if (gra) begin
            sel = ir[26:23];
        end else if (grb) begin
            sel = ir[22:19];
        end else if (grc) begin
            sel = ir[18:15];
        end else begin
            sel = '0;
        end
    end

    // R0 as a base address means absolute
    assign regData = (baOut && sel == '0) ? '0 : regs[sel];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < cpuPkg::NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regIn) begin
            regs[sel] <= busIn;
        end
    end

endmodule

// File: logic/memWaitTimer.sv
`timescale 1ns/10ps

module memWaitTimer (
    input  logic clk,
    input  logic reset,
    input  logic memRead,
    output logic memReady
);

    logic busy;
    cpuPkg::waitCountT count;
    cpuPkg::waitCountT remaining;

    // First cycle of a read starts from the full wait count
    assign remaining = busy ? count : cpuPkg::waitCountT'(cpuPkg::MemWaitCycles);
    assign memReady = memRead && (remaining == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            count <= '0;
        end else if (!memRead || memReady) begin
            busy <= 1'b0;
        end else begin
            busy <= 1'b1;
            count <= remaining - 1'b1;
        end
    end

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic stop,
    input  cpuPkg::opcodeT opcode,
    input  logic memReady,
    output logic run,
    // Bus sources, one-hot
    output logic regOut,
    output logic pcOut,
    output logic mdrOut,
    output logic zLowOut,
    output logic cOut,
    // Register loads
    output logic regIn,
    output logic pcIn,
    output logic irIn,
    output logic yIn,
    output logic zIn,
    output logic outPortIn,
    // ALU and register select
    output logic incPc,
    output cpuPkg::aluOpT aluOp,
    output logic gra,
    output logic grb,
    output logic grc,
    output logic baOut,
    // Memory
    output logic marIn,
    output logic mdrIn,
    output logic memRead,
    output logic memWrite
);

    cpuPkg::ctrlStateT state;
    cpuPkg::ctrlStateT nextState;
    logic stopPending;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cpuPkg::Idle;
            stopPending <= 1'b0;
        end else begin
            state <= nextState;
            // Stop is only looked at during Fetch0
            if (state == cpuPkg::Fetch0 && stop) begin
                stopPending <= 1'b1;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            cpuPkg::Idle: begin
                if (start) begin
                    nextState = cpuPkg::Fetch0;
                end
            end
            cpuPkg::Fetch0: nextState = cpuPkg::Fetch1;
            cpuPkg::Fetch1: begin
                if (memReady) begin
                    nextState = cpuPkg::Fetch2;
                end
            end
            // Opcode here is the word being loaded into IR
            cpuPkg::Fetch2: begin
                if (stopPending) begin
                    nextState = cpuPkg::Halted;
                end else begin
                    case (opcode)
                        cpuPkg::OpLd, cpuPkg::OpLdi, cpuPkg::OpSt: nextState = cpuPkg::Mem3;
                        cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpAnd, cpuPkg::OpOr,
                        cpuPkg::OpShl, cpuPkg::OpShr, cpuPkg::OpNeg, cpuPkg::OpNot:
                            nextState = cpuPkg::Alu3;
                        cpuPkg::OpOut: nextState = cpuPkg::Out3;
                        default: nextState = cpuPkg::Halted;
                    endcase
                end
            end
            cpuPkg::Mem3: nextState = cpuPkg::Mem4;
            cpuPkg::Mem4: begin
                nextState = (opcode == cpuPkg::OpLdi) ? cpuPkg::Ldi5 : cpuPkg::Mem5;
            end
            cpuPkg::Mem5: begin
                nextState = (opcode == cpuPkg::OpLd) ? cpuPkg::Ld6 : cpuPkg::St6;
            end
            cpuPkg::Ldi5: nextState = cpuPkg::Fetch0;
            cpuPkg::Ld6: begin
                if (memReady) begin
                    nextState = cpuPkg::Ld7;
                end
            end
            cpuPkg::Ld7: nextState = cpuPkg::Fetch0;
            cpuPkg::St6: nextState = cpuPkg::Fetch0;
            cpuPkg::Alu3: nextState = cpuPkg::Alu4;
            cpuPkg::Alu4: nextState = cpuPkg::Alu5;
            cpuPkg::Alu5: nextState = cpuPkg::Fetch0;
            cpuPkg::Out3: nextState = cpuPkg::Fetch0;
            cpuPkg::Halted: nextState = cpuPkg::Halted;
            default: nextState = cpuPkg::Idle;
        endcase
    end

    assign run = (state != cpuPkg::Idle) && (state != cpuPkg::Halted);

    always_comb begin
        regOut = 1'b0;
        pcOut = 1'b0;
        mdrOut = 1'b0;
        zLowOut = 1'b0;
        cOut = 1'b0;
        regIn = 1'b0;
        pcIn = 1'b0;
        irIn = 1'b0;
        yIn = 1'b0;
        zIn = 1'b0;
        outPortIn = 1'b0;
        incPc = 1'b0;
        aluOp = cpuPkg::AluAdd;
        gra = 1'b0;
        grb = 1'b0;
        grc = 1'b0;
        baOut = 1'b0;
        marIn = 1'b0;
        mdrIn = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        case (state)
            cpuPkg::Fetch0: begin
                pcOut = 1'b1;
                marIn = 1'b1;
                incPc = 1'b1;
                zIn = 1'b1;
            end
            // Held until the timer reports data ready
            cpuPkg::Fetch1: begin
                zLowOut = 1'b1;
                pcIn = 1'b1;
                memRead = 1'b1;
                mdrIn = 1'b1;
            end
            cpuPkg::Fetch2: begin
                mdrOut = 1'b1;
                irIn = 1'b1;
            end
            // Base register, R0 reads as zero here
            cpuPkg::Mem3: begin
                grb = 1'b1;
                baOut = 1'b1;
                regOut = 1'b1;
                yIn = 1'b1;
            end
            cpuPkg::Mem4: begin
                cOut = 1'b1;
                zIn = 1'b1;
            end
            cpuPkg::Mem5: begin
                zLowOut = 1'b1;
                marIn = 1'b1;
            end
            cpuPkg::Ldi5, cpuPkg::Alu5: begin
                zLowOut = 1'b1;
                gra = 1'b1;
                regIn = 1'b1;
            end
            cpuPkg::Ld6: begin
                memRead = 1'b1;
                mdrIn = 1'b1;
            end
            cpuPkg::Ld7: begin
                mdrOut = 1'b1;
                gra = 1'b1;
                regIn = 1'b1;
            end
            // ra goes into MDR and the RAM in the same cycle
            cpuPkg::St6: begin
                gra = 1'b1;
                regOut = 1'b1;
                mdrIn = 1'b1;
                memWrite = 1'b1;
            end
            cpuPkg::Alu3: begin
                grb = 1'b1;
                regOut = 1'b1;
                yIn = 1'b1;
            end
            cpuPkg::Alu4: begin
                grc = 1'b1;
                regOut = 1'b1;
                zIn = 1'b1;
                aluOp = cpuPkg::aluOpT'(opcode - cpuPkg::OpAdd);
            end
            cpuPkg::Out3: begin
                gra = 1'b1;
                regOut = 1'b1;
                outPortIn = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: logic/cpuPkg.sv
package cpuPkg;

    // Datapath widths
    localparam int DataWidth = 32;
    localparam int OpcodeWidth = 5;
    localparam int RegIndexWidth = 4;
    localparam int NumRegs = 16;
    localparam int AluOpWidth = 4;
    localparam int ConstWidth = 19;
    localparam int ShiftWidth = $clog2(DataWidth);

    // 512-word memory
    localparam int MemAddrWidth = 9;
    localparam int MemDepth = 512;

    // Cycles from read request to valid data
    localparam int MemWaitCycles = 2;
    localparam int WaitCountWidth = $clog2(MemWaitCycles + 1);

    typedef logic [DataWidth-1:0] wordT;
    typedef logic [OpcodeWidth-1:0] opcodeT;
    typedef logic [RegIndexWidth-1:0] regIndexT;
    typedef logic [MemAddrWidth-1:0] memAddrT;
    typedef logic [AluOpWidth-1:0] aluOpT;
    typedef logic [WaitCountWidth-1:0] waitCountT;

    // Opcodes in IR[31:27]
    localparam opcodeT OpLd = 5'd0;
    localparam opcodeT OpLdi = 5'd1;
    localparam opcodeT OpSt = 5'd2;
    localparam opcodeT OpAdd = 5'd3;
    localparam opcodeT OpSub = 5'd4;
    localparam opcodeT OpAnd = 5'd5;
    localparam opcodeT OpOr = 5'd6;
    localparam opcodeT OpShl = 5'd7;
    localparam opcodeT OpShr = 5'd8;
    localparam opcodeT OpNeg = 5'd9;
    localparam opcodeT OpNot = 5'd10;
    localparam opcodeT OpOut = 5'd11;
    localparam opcodeT OpHalt = 5'd12;

    // ALU selects, same order as the ALU opcodes
    localparam aluOpT AluAdd = 4'd0;
    localparam aluOpT AluSub = 4'd1;
    localparam aluOpT AluAnd = 4'd2;
    localparam aluOpT AluOr = 4'd3;
    localparam aluOpT AluShl = 4'd4;
    localparam aluOpT AluShr = 4'd5;
    localparam aluOpT AluNeg = 4'd6;
    localparam aluOpT AluNot = 4'd7;

    typedef enum logic [3:0] {
        Idle,
        Fetch0,
        Fetch1,
        Fetch2,
        Mem3,
        Mem4,
        Mem5,
        Ldi5,
        Ld6,
        Ld7,
        St6,
        Alu3,
        Alu4,
        Alu5,
        Out3,
        Halted
    } ctrlStateT;

endpackage
